// File: bist_macros.svh
// ================================================
// Global widths and host register map for the BIST
// engine. Include wherever these values are used.
// ================================================

`ifndef BIST_MACROS_SVH
`define BIST_MACROS_SVH

// Pattern and signature width
`define BIST_WIDTH 32

// Pattern count register width
`define BIST_CNT_WIDTH 16

// Host register map
`define BIST_ADDR_WIDTH 2
`define BIST_ADDR_SEED 2'd0
`define BIST_ADDR_COUNT 2'd1
`define BIST_ADDR_GOLDEN 2'd2
`define BIST_ADDR_START 2'd3

`endif

// File: bist_cfg_pkg.sv
// ================================================
// Host side types: the write port word and the run
// configuration held by the register block.
// ================================================

`include "bist_macros.svh"

package bist_cfg_pkg;

    // One host write, qualified by wr_en beside it
    typedef struct packed {
        logic [`BIST_ADDR_WIDTH-1:0] addr;
        logic [`BIST_WIDTH-1:0]      data;
    } host_wr_t;

    // Everything a run needs, latched by the controller at start
    typedef struct packed {
        logic [`BIST_WIDTH-1:0]     seed;
        logic [`BIST_CNT_WIDTH-1:0] count;
        logic [`BIST_WIDTH-1:0]     golden;
    } bist_cfg_t;

endpackage

// File: bist_data_pkg.sv
// ================================================
// Datapath and status types shared by controller,
// LFSR, CUT, MISR and the top level.
// ================================================

`include "bist_macros.svh"

package bist_data_pkg;

    // Test pattern, also used for CUT responses
    typedef logic [`BIST_WIDTH-1:0] pattern_t;

    // Compacted MISR state
    typedef logic [`BIST_WIDTH-1:0] signature_t;

    // Seed message to the LFSR, val and rdy travel beside it
    typedef struct packed {
        logic [`BIST_WIDTH-1:0] seed;
    } lfsr_req_t;

    // Run status seen by the host
    typedef struct packed {
        logic       busy;
        logic       done;
        logic       pass;
        signature_t signature;
    } bist_status_t;

endpackage

// File: bist_lfsr.sv
// ================================================
// Seeded pattern generator. Takes a seed over val/rdy,
// then steps once per accepted pattern until cleared.
// ================================================

module bist_lfsr #(
    parameter int lfsr_bits = 32
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     seed_val,
    input  bist_data_pkg::lfsr_req_t seed_msg,
    output logic                     seed_rdy,
    input  logic                     clear,
    output logic                     pat_val,
    output bist_data_pkg::pattern_t  pattern,
    input  logic                     pat_rdy
);
    import bist_data_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_GEN
    } lfsr_state_t;

    lfsr_state_t          state;
    logic [lfsr_bits-1:0] q;
    logic [lfsr_bits-1:0] q_next;
    logic                 feedback;

    // ================================================
    // Feedback taps, four-tap XNOR for each width
    // ================================================
    generate
        if (lfsr_bits == 8) begin : g_taps_8
            assign feedback = ~(q[3] ^ q[4] ^ q[5] ^ q[7]);
        end else if (lfsr_bits == 16) begin : g_taps_16
            assign feedback = ~(q[10] ^ q[12] ^ q[13] ^ q[15]);
        end else if (lfsr_bits == 32) begin : g_taps_32
            assign feedback = ~(q[24] ^ q[25] ^ q[29] ^ q[31]);
        end else begin : g_taps_bad
            $error("bist_lfsr: lfsr_bits must be 8, 16 or 32");
        end
    endgenerate

    assign q_next = {q[lfsr_bits-2:0], feedback};

    // ================================================
    // Control and shift register
    // ================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else if (clear) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (seed_val) state <= S_GEN;
                S_GEN:   state <= S_GEN;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Seed loads on the handshake, steps only when a pattern is taken
    always_ff @(posedge clk) begin
        if (seed_val && seed_rdy) begin
            q <= seed_msg.seed[lfsr_bits-1:0];
        end else if (pat_val && pat_rdy) begin
            q <= q_next;
        end
    end

    assign seed_rdy = (state == S_IDLE);
    assign pat_val  = (state == S_GEN);

    // Narrow LFSRs are zero extended onto the pattern bus
    assign pattern = pat_val ? pattern_t'(q) : '0;

endmodule

// File: bist_cut.sv
// ================================================
// Circuit under test: one registered stage of
// rotate, add and XOR. Accepts a new item each cycle.
// ================================================

module bist_cut (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_val,
    input  bist_data_pkg::pattern_t pattern,
    output logic                    out_val,
    output bist_data_pkg::pattern_t response
);
    import bist_data_pkg::*;

    pattern_t rotated;
    pattern_t mixed;

    // Rotate left by 7
    assign rotated = {pattern[$bits(pattern_t)-8:0], pattern[$bits(pattern_t)-1 -: 7]};

    // Sum wraps at the word width, then the constant is XORed in
    assign mixed = (pattern + rotated) ^ 32'hA5A5_A5A5;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_val <= 1'b0;
        end else begin
            out_val <= in_val;
        end
    end

    always_ff @(posedge clk) begin
        if (in_val) begin
            response <= mixed;
        end
    end

endmodule

// File: bist_misr.sv
// ================================================
// Multiple-input signature register. Folds every
// valid CUT response into a 32-bit signature.
// ================================================

module bist_misr (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      clear,
    input  logic                      in_val,
    input  bist_data_pkg::pattern_t   response,
    output bist_data_pkg::signature_t signature
);
    import bist_data_pkg::*;

    signature_t sig_q;
    signature_t sig_shift;
    logic       fb;

    // Feedback from bits 31, 21, 1 and 0
    assign fb        = sig_q[31] ^ sig_q[21] ^ sig_q[1] ^ sig_q[0];
    assign sig_shift = {sig_q[$bits(signature_t)-2:0], fb};

    // ================================================
    // Signature register
    // ================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            sig_q <= '0;
        end else if (clear) begin
            // Clear wins over a response in the same cycle
            sig_q <= '0;
        end else if (in_val) begin
            sig_q <= sig_shift ^ response;
        end
    end

    assign signature = sig_q;

endmodule

// File: bist_ctrl.sv
// ================================================
// Run sequencer: seeds the LFSR, takes N patterns,
// drains the CUT and checks the signature.
// ================================================

`include "bist_macros.svh"

module bist_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  bist_cfg_pkg::bist_cfg_t     cfg,
    input  logic                        start,
    output logic                        seed_val,
    output bist_data_pkg::lfsr_req_t    seed_msg,
    input  logic                        seed_rdy,
    input  logic                        pat_val,
    output logic                        pat_rdy,
    output logic                        lfsr_clear,
    output logic                        misr_clear,
    input  bist_data_pkg::signature_t   signature,
    output bist_data_pkg::bist_status_t status
);
    import bist_cfg_pkg::*;
    import bist_data_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_SEED,
        S_RUN,
        S_DRAIN,
        S_FINISH
    } ctrl_state_t;

    ctrl_state_t                state;
    bist_cfg_t                  cfg_q;
    logic [`BIST_CNT_WIDTH-1:0] pat_cnt;
    logic                       last_pat;
    logic                       done_q;
    logic                       pass_q;
    signature_t                 sig_q;

    assign last_pat = (pat_cnt == cfg_q.count - 1'b1);

    // ================================================
    // State machine
    // ================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            pat_cnt <= '0;
            done_q  <= 1'b0;
            pass_q  <= 1'b0;
            sig_q   <= '0;
        end else begin
            done_q <= 1'b0;
            case (state)
                S_IDLE: begin
                    // Start only counts here, so a start while busy is dropped
                    if (start) begin
                        state   <= S_SEED;
                        pat_cnt <= '0;
                        pass_q  <= 1'b0;
                        sig_q   <= '0;
                    end
                end
                S_SEED: begin
                    if (seed_val && seed_rdy) begin
                        state <= (cfg_q.count == '0) ? S_DRAIN : S_RUN;
                    end
                end
                S_RUN: begin
                    if (pat_val && pat_rdy) begin
                        pat_cnt <= pat_cnt + 1'b1;
                        if (last_pat) state <= S_DRAIN;
                    end
                end
                // Last response lands in the MISR at the end of this cycle
                S_DRAIN: state <= S_FINISH;
                S_FINISH: begin
                    done_q <= 1'b1;
                    pass_q <= (signature == cfg_q.golden);
                    sig_q  <= signature;
                    state  <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Configuration snapshot for the whole run
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            cfg_q <= cfg;
        end
    end

    assign seed_val   = (state == S_SEED);
    assign seed_msg   = '{seed: cfg_q.seed};
    assign misr_clear = (state == S_SEED);
    assign pat_rdy    = (state == S_RUN);
    assign lfsr_clear = (state == S_FINISH);

    assign status = '{busy: (state != S_IDLE), done: done_q, pass: pass_q, signature: sig_q};

endmodule

// File: bist_regs.sv
// ================================================
// Host configuration registers. Decodes writes by
// address and turns a START write into a strobe.
// ================================================

`include "bist_macros.svh"

module bist_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_en,
    input  bist_cfg_pkg::host_wr_t  wr,
    output bist_cfg_pkg::bist_cfg_t cfg,
    output logic                    start
);

    // ================================================
    // Write decode
    // ================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg   <= '0;
            start <= 1'b0;
        end else begin
            // One cycle strobe, the controller decides whether to take it
            start <= wr_en && (wr.addr == `BIST_ADDR_START) && wr.data[0];

            if (wr_en) begin
                case (wr.addr)
                    `BIST_ADDR_SEED:   cfg.seed   <= wr.data;
                    `BIST_ADDR_COUNT:  cfg.count  <= wr.data[`BIST_CNT_WIDTH-1:0];
                    `BIST_ADDR_GOLDEN: cfg.golden <= wr.data;
                    // Start holds no state of its own
                    `BIST_ADDR_START:  ;
                    default:           ;
                endcase
            end
        end
    end

endmodule

// File: bist_top.sv
// ================================================
// BIST engine top level. Host writes configure and
// start a run, status reports the result.
// ================================================

`include "bist_macros.svh"

module bist_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wr_en,
    input  bist_cfg_pkg::host_wr_t      wr,
    output bist_data_pkg::bist_status_t status
);
    import bist_cfg_pkg::*;
    import bist_data_pkg::*;

    bist_cfg_t  cfg;
    logic       start;
    logic       seed_val;
    logic       seed_rdy;
    lfsr_req_t  seed_msg;
    logic       pat_val;
    logic       pat_rdy;
    logic       pat_fire;
    pattern_t   pattern;
    logic       lfsr_clear;
    logic       misr_clear;
    logic       resp_val;
    pattern_t   response;
    signature_t signature;

    // A pattern enters the CUT on the handshake
    assign pat_fire = pat_val & pat_rdy;

    bist_regs i_regs (
        .clk   (clk),
        .reset (reset),
        .wr_en (wr_en),
        .wr    (wr),
        .cfg   (cfg),
        .start (start)
    );

    bist_ctrl i_ctrl (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .start      (start),
        .seed_val   (seed_val),
        .seed_msg   (seed_msg),
        .seed_rdy   (seed_rdy),
        .pat_val    (pat_val),
        .pat_rdy    (pat_rdy),
        .lfsr_clear (lfsr_clear),
        .misr_clear (misr_clear),
        .signature  (signature),
        .status     (status)
    );

    bist_lfsr #(
        .lfsr_bits (`BIST_WIDTH)
    ) i_lfsr (
        .clk      (clk),
        .reset    (reset),
        .seed_val (seed_val),
        .seed_msg (seed_msg),
        .seed_rdy (seed_rdy),
        .clear    (lfsr_clear),
        .pat_val  (pat_val),
        .pattern  (pattern),
        .pat_rdy  (pat_rdy)
    );

    bist_cut i_cut (
        .clk      (clk),
        .reset    (reset),
        .in_val   (pat_fire),
        .pattern  (pattern),
        .out_val  (resp_val),
        .response (response)
    );

    bist_misr i_misr (
        .clk       (clk),
        .reset     (reset),
        .clear     (misr_clear),
        .in_val    (resp_val),
        .response  (response),
        .signature (signature)
    );

endmodule

// File: bist_properties.sv
// ================================================
// Protocol assertions for the BIST controller,
// attached to every bist_ctrl instance by bind.
// ================================================

module bist_properties (
    input logic clk,
    input logic reset,
    input logic start,
    input logic seed_val,
    input logic seed_rdy,
    input logic pat_rdy,
    input logic busy,
    input logic done
);

    // Failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    // done lasts exactly one cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for more than one cycle");
        end

    // Seed request only between an accepted start and the seed handshake
    a_seed_val_state: assert property (@(posedge clk) disable iff (reset)
        seed_val |-> ($past(start && !busy) || $past(seed_val && !seed_rdy)))
        else begin
            fail_count++;
            $error("seed_val high outside the seed state");
        end

    // No pattern is taken when no run is active
    a_pat_rdy_busy: assert property (@(posedge clk) disable iff (reset) pat_rdy |-> busy)
        else begin
            fail_count++;
            $error("pat_rdy high while busy is low");
        end

endmodule

bind bist_ctrl bist_properties i_props (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .seed_val (seed_val),
    .seed_rdy (seed_rdy),
    .pat_rdy  (pat_rdy),
    .busy     (status.busy),
    .done     (status.done)
);

// File: tb_bist_top.sv
// ================================================
// Directed testbench for the BIST engine. Runs are
// checked against a software model of LFSR, CUT and MISR.
// ================================================

`include "bist_macros.svh"

module tb_bist_top;
    import bist_cfg_pkg::*;
    import bist_data_pkg::*;

    localparam int N_SHORT  = 1;
    localparam int N_LONG   = 20;
    localparam int N_FIRST  = 12;
    localparam int N_SECOND = 17;
    // N+10 cycles for each of the six runs plus a margin
    localparam int WATCHDOG_CYCLES = (N_SHORT + 10) + 3 * (N_LONG + 10)
                                   + (N_FIRST + 10) + (N_SECOND + 10) + 100;

    logic         clk;
    logic         reset;
    logic         wr_en;
    host_wr_t     wr;
    bist_status_t status;

    int         checks;
    int         errors;
    int         tests_run;
    int         tests_failed;
    pattern_t   shared_seed;
    signature_t shared_sig;

    bist_top i_bist_top (
        .clk    (clk),
        .reset  (reset),
        .wr_en  (wr_en),
        .wr     (wr),
        .status (status)
    );

    always #10 clk = ~clk;

    // ================================================
    // Reference model and compare tasks
    // ================================================
    task automatic model_signature(input pattern_t seed, input int n, output signature_t sig);
        pattern_t pat;
        pattern_t resp;
        logic     fb;
        sig = '0;
        pat = seed;
        for (int i = 0; i < n; i++) begin
            // CUT adds the pattern to its rotation by 7 and XORs a constant
            resp = (pat + ((pat << 7) | (pat >> 25))) ^ 32'hA5A5_A5A5;
            fb   = sig[31] ^ sig[21] ^ sig[1] ^ sig[0];
            sig  = {sig[30:0], fb} ^ resp;
            pat  = {pat[30:0], ~(pat[24] ^ pat[25] ^ pat[29] ^ pat[31])};
        end
    endtask

    task automatic check_signature(input string name, input signature_t got,
                                   input signature_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %08h, expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_status_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int base);
        tests_run++;
        if (errors == base) begin
            $display("[%0t] %s: ok", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: %0d errors", $time, name, errors - base);
        end
    endtask

    // ================================================
    // Host port helpers for use on a falling edge
    // ================================================
    task automatic host_write(input logic [`BIST_ADDR_WIDTH-1:0] addr,
                              input logic [`BIST_WIDTH-1:0] data);
        wr_en   = 1'b1;
        wr.addr = addr;
        wr.data = data;
        @(negedge clk);
        wr_en = 1'b0;
        wr    = '0;
    endtask

    task automatic load_config(input pattern_t seed, input int count, input signature_t golden);
        host_write(`BIST_ADDR_SEED, seed);
        host_write(`BIST_ADDR_COUNT, 32'(count));
        host_write(`BIST_ADDR_GOLDEN, golden);
    endtask

    // Cycles counts falling edges since the start write was taken
    task automatic wait_done(input int limit, inout int cycles);
        while (!status.done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!status.done) begin
            errors++;
            $display("ERROR t=%0t done did not arrive within %0d cycles of start", $time, limit);
        end
    endtask

    task automatic run_and_wait(input pattern_t seed, input int n, input signature_t golden);
        int cycles;
        load_config(seed, n, golden);
        host_write(`BIST_ADDR_START, 32'h1);
        cycles = 0;
        check_status_bit("status.busy", status.busy, 1'b0);
        @(negedge clk);
        cycles = 1;
        check_status_bit("status.busy", status.busy, 1'b1);
        wait_done(n + 20, cycles);
        check_latency("done latency", cycles, n + 4);
    endtask

    // ================================================
    // Directed tests
    // ================================================
    task automatic idle_after_reset();
        int base;
        base = errors;
        check_status_bit("status.busy", status.busy, 1'b0);
        check_status_bit("status.done", status.done, 1'b0);
        check_status_bit("status.pass", status.pass, 1'b0);
        check_signature("status.signature", status.signature, '0);
        report_test("idle after reset", base);
    endtask

    task automatic single_pattern_run();
        int         base;
        signature_t exp_sig;
        base = errors;
        model_signature(32'h1234_5678, N_SHORT, exp_sig);
        run_and_wait(32'h1234_5678, N_SHORT, exp_sig);
        check_status_bit("status.pass", status.pass, 1'b1);
        check_signature("status.signature", status.signature, exp_sig);
        report_test("single pattern run", base);
    endtask

    task automatic random_seed_pass();
        int base;
        base = errors;
        shared_seed = $urandom();
        model_signature(shared_seed, N_LONG, shared_sig);
        run_and_wait(shared_seed, N_LONG, shared_sig);
        check_status_bit("status.pass", status.pass, 1'b1);
        check_signature("status.signature", status.signature, shared_sig);
        report_test("random seed pass", base);
    endtask

    task automatic flipped_golden_fail();
        int base;
        int flip;
        base = errors;
        flip = $urandom_range(31, 0);
        run_and_wait(shared_seed, N_LONG, shared_sig ^ (32'h1 << flip));
        check_status_bit("status.pass", status.pass, 1'b0);
        check_signature("status.signature", status.signature, shared_sig);
        report_test("flipped golden fail", base);
    endtask

    task automatic back_to_back_runs();
        int         base;
        pattern_t   seed_a;
        pattern_t   seed_b;
        signature_t sig_a;
        signature_t sig_b;
        base   = errors;
        seed_a = $urandom();
        seed_b = $urandom();
        if (seed_b == seed_a) seed_b = ~seed_a;
        model_signature(seed_a, N_FIRST, sig_a);
        model_signature(seed_b, N_SECOND, sig_b);
        run_and_wait(seed_a, N_FIRST, sig_a);
        check_status_bit("status.pass", status.pass, 1'b1);
        check_signature("status.signature", status.signature, sig_a);
        run_and_wait(seed_b, N_SECOND, sig_b);
        check_status_bit("status.pass", status.pass, 1'b1);
        check_signature("status.signature", status.signature, sig_b);
        report_test("back to back runs", base);
    endtask

    task automatic start_ignored_while_busy();
        int         base;
        int         cycles;
        pattern_t   seed;
        signature_t exp_sig;
        base = errors;
        seed = $urandom();
        model_signature(seed, N_LONG, exp_sig);
        load_config(seed, N_LONG, exp_sig);
        host_write(`BIST_ADDR_START, 32'h1);
        cycles = 0;
        repeat (5) begin
            @(negedge clk);
            cycles++;
        end
        check_status_bit("status.busy", status.busy, 1'b1);
        // Second start lands mid-run
        host_write(`BIST_ADDR_START, 32'h1);
        cycles++;
        wait_done(N_LONG + 20, cycles);
        check_latency("done latency", cycles, N_LONG + 4);
        check_status_bit("status.pass", status.pass, 1'b1);
        check_signature("status.signature", status.signature, exp_sig);
        repeat (4) begin
            @(negedge clk);
            check_status_bit("status.busy", status.busy, 1'b0);
        end
        check_status_bit("status.pass", status.pass, 1'b1);
        check_signature("status.signature", status.signature, exp_sig);
        report_test("start ignored while busy", base);
    endtask

    // ================================================
    // Main sequence and watchdog
    // ================================================
    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        wr_en        = 1'b0;
        wr           = '0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(42));
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        idle_after_reset();
        single_pattern_run();
        random_seed_pass();
        flipped_golden_fail();
        back_to_back_runs();
        start_ignored_while_busy();

        // Assertion failures in the bound checker count as errors
        errors = errors + i_bist_top.i_ctrl.i_props.fail_count;

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: bist_top.f
+incdir+.
bist_cfg_pkg.sv
bist_data_pkg.sv
bist_lfsr.sv
bist_cut.sv
bist_misr.sv
bist_ctrl.sv
bist_regs.sv
bist_top.sv
bist_properties.sv
tb_bist_top.sv

// File: Makefile
# Verilator build of the BIST engine testbench

LOG = sim.log

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_bist_top -f bist_top.f --Mdir obj_dir

run: compile
	-./obj_dir/Vtb_bist_top > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -F -q '** FAIL **' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -F -q '** PASS **' $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

.PHONY: compile run clean
